/* include/mul_cfg.svh */
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

`define MUL_REG_SIZE    32      // Operand and result word width
`define MUL_REG_ADDR    5       // Destination register tag width
`define MUL_FUNCT_SIZE  6
`define MUL_FUNCT_MULT  6'h18   // MIPS mult
`define MUL_FUNCT_MULTU 6'h19   // MIPS multu
`define MUL_HALF        16      // Split point for the partial products
`define MUL_STAGES      5       // Pipeline depth, M1 to M5

`endif

/* hw/mul_pkg.sv */
`include "mul_cfg.svh"

package mul_pkg;

   // Request as seen at the pipeline input
   typedef struct packed {
      logic [`MUL_FUNCT_SIZE-1:0] funct;
      logic [`MUL_REG_ADDR-1:0]   tag;
      logic [`MUL_REG_SIZE-1:0]   a;
      logic [`MUL_REG_SIZE-1:0]   b;
   } mul_req_t;

   // M1 output, operands as magnitudes
   typedef struct packed {
      logic [`MUL_REG_ADDR-1:0]   tag;
      logic                       neg;        // Product must be negated
      logic                       is_signed;
      logic [`MUL_REG_SIZE-1:0]   mag_a;
      logic [`MUL_REG_SIZE-1:0]   mag_b;
   } mul_mag_t;

   // M2 output, four half-word products
   typedef struct packed {
      logic [`MUL_REG_ADDR-1:0]   tag;
      logic                       neg;
      logic                       is_signed;
      logic [`MUL_REG_SIZE-1:0]   p_ll;       // a_lo * b_lo
      logic [`MUL_REG_SIZE-1:0]   p_lh;       // a_lo * b_hi
      logic [`MUL_REG_SIZE-1:0]   p_hl;       // a_hi * b_lo
      logic [`MUL_REG_SIZE-1:0]   p_hh;       // a_hi * b_hi
   } mul_part_t;

   // M3 output, unsigned product magnitude
   typedef struct packed {
      logic [`MUL_REG_ADDR-1:0]   tag;
      logic                       neg;
      logic                       is_signed;
      logic [2*`MUL_REG_SIZE-1:0] mag;
   } mul_sum_t;

   // Final result, M4 onwards
   typedef struct packed {
      logic [`MUL_REG_ADDR-1:0]   tag;
      logic [`MUL_REG_SIZE-1:0]   lo;
      logic [`MUL_REG_SIZE-1:0]   hi;
      logic                       zero;
      logic                       overflow;   // Product does not fit in lo
   } mul_res_t;

endpackage

/* hw/mul_operand_stage.sv */
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_operand_stage (
   input  logic              clk,
   input  logic              mem_wb_reset,
   input  logic              advance,
   input  logic              in_valid,
   input  mul_pkg::mul_req_t in_req,
   output logic              valid,
   output mul_pkg::mul_mag_t mag
);
   import mul_pkg::*;

   logic     is_signed;
   logic     neg_a;
   logic     neg_b;
   mul_mag_t mag_next;

   // Anything other than mult is treated as unsigned
   assign is_signed = (in_req.funct == `MUL_FUNCT_MULT);
   assign neg_a     = is_signed & in_req.a[`MUL_REG_SIZE-1];
   assign neg_b     = is_signed & in_req.b[`MUL_REG_SIZE-1];

   always_comb begin
      mag_next.tag       = in_req.tag;
      mag_next.is_signed = is_signed;
      mag_next.neg       = neg_a ^ neg_b;
      // Magnitude of 0x80000000 is itself when read as unsigned
      mag_next.mag_a     = neg_a ? -in_req.a : in_req.a;
      mag_next.mag_b     = neg_b ? -in_req.b : in_req.b;
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         valid <= 1'b0;
      end else if (advance) begin
         valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         mag <= mag_next;   // Frozen on stall
      end
   end

endmodule

/* hw/mul_partial_stage.sv */
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_partial_stage (
   input  logic               clk,
   input  logic               mem_wb_reset,
   input  logic               advance,
   input  logic               in_valid,
   input  mul_pkg::mul_mag_t  in_mag,
   output logic               valid,
   output mul_pkg::mul_part_t part
);
   import mul_pkg::*;

   logic [`MUL_HALF-1:0] a_lo;
   logic [`MUL_HALF-1:0] a_hi;
   logic [`MUL_HALF-1:0] b_lo;
   logic [`MUL_HALF-1:0] b_hi;
   mul_part_t            part_next;

   assign a_lo = in_mag.mag_a[`MUL_HALF-1:0];
   assign a_hi = in_mag.mag_a[`MUL_REG_SIZE-1:`MUL_HALF];
   assign b_lo = in_mag.mag_b[`MUL_HALF-1:0];
   assign b_hi = in_mag.mag_b[`MUL_REG_SIZE-1:`MUL_HALF];

   always_comb begin
      part_next.tag       = in_mag.tag;
      part_next.neg       = in_mag.neg;
      part_next.is_signed = in_mag.is_signed;
      // Operands widened so the 16x16 products keep all 32 bits
      part_next.p_ll      = {{`MUL_HALF{1'b0}}, a_lo} * {{`MUL_HALF{1'b0}}, b_lo};
      part_next.p_lh      = {{`MUL_HALF{1'b0}}, a_lo} * {{`MUL_HALF{1'b0}}, b_hi};
      part_next.p_hl      = {{`MUL_HALF{1'b0}}, a_hi} * {{`MUL_HALF{1'b0}}, b_lo};
      part_next.p_hh      = {{`MUL_HALF{1'b0}}, a_hi} * {{`MUL_HALF{1'b0}}, b_hi};
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         valid <= 1'b0;
      end else if (advance) begin
         valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         part <= part_next;
      end
   end

endmodule

/* hw/mul_accum_stage.sv */
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_accum_stage (
   input  logic               clk,
   input  logic               mem_wb_reset,
   input  logic               advance,
   input  logic               in_valid,
   input  mul_pkg::mul_part_t in_part,
   output logic               valid,
   output mul_pkg::mul_sum_t  sum
);
   import mul_pkg::*;

   logic [2*`MUL_REG_SIZE-1:0] w_ll;
   logic [2*`MUL_REG_SIZE-1:0] w_mid;   // Both cross terms, weight 2^16
   logic [2*`MUL_REG_SIZE-1:0] w_hh;
   mul_sum_t                   sum_next;

   assign w_ll  = {{`MUL_REG_SIZE{1'b0}}, in_part.p_ll};
   assign w_mid = ({{`MUL_REG_SIZE{1'b0}}, in_part.p_lh} << `MUL_HALF)
                + ({{`MUL_REG_SIZE{1'b0}}, in_part.p_hl} << `MUL_HALF);
   assign w_hh  = {in_part.p_hh, {`MUL_REG_SIZE{1'b0}}};

   always_comb begin
      sum_next.tag       = in_part.tag;
      sum_next.neg       = in_part.neg;
      sum_next.is_signed = in_part.is_signed;
      sum_next.mag       = w_ll + w_mid + w_hh;
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         valid <= 1'b0;
      end else if (advance) begin
         valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         sum <= sum_next;
      end
   end

endmodule

/* hw/mul_flag_stage.sv */
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_flag_stage (
   input  logic              clk,
   input  logic              mem_wb_reset,
   input  logic              advance,
   input  logic              in_valid,
   input  mul_pkg::mul_sum_t in_sum,
   output logic              valid,
   output mul_pkg::mul_res_t res
);
   import mul_pkg::*;

   logic [2*`MUL_REG_SIZE-1:0] prod;
   logic [`MUL_REG_SIZE-1:0]   lo;
   logic [`MUL_REG_SIZE-1:0]   hi;
   logic                       ovf_signed;
   logic                       ovf_unsigned;
   mul_res_t                   res_next;

   // Two's complement restores the sign
   assign prod = in_sum.neg ? -in_sum.mag : in_sum.mag;
   assign lo   = prod[`MUL_REG_SIZE-1:0];
   assign hi   = prod[2*`MUL_REG_SIZE-1:`MUL_REG_SIZE];

   // Signed fits only if hi is just the sign extension of lo
   assign ovf_signed   = (hi != {`MUL_REG_SIZE{lo[`MUL_REG_SIZE-1]}});
   assign ovf_unsigned = (hi != '0);

   always_comb begin
      res_next.tag      = in_sum.tag;
      res_next.lo       = lo;
      res_next.hi       = hi;
      res_next.zero     = (prod == '0);
      res_next.overflow = in_sum.is_signed ? ovf_signed : ovf_unsigned;
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         valid <= 1'b0;
      end else if (advance) begin
         valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         res <= res_next;
      end
   end

endmodule

/* hw/mul_output_stage.sv */
`timescale 1ns/1ps

module mul_output_stage (
   input  logic              clk,
   input  logic              mem_wb_reset,
   input  logic              in_valid,
   input  mul_pkg::mul_res_t in_res,
   input  logic              out_ready,
   output logic              out_valid,
   output mul_pkg::mul_res_t out_res,
   output logic              advance
);
   import mul_pkg::*;

   mul_res_t res_q;

   // Single stall decision for the whole pipeline.
   // A held result that nobody takes freezes every stage, the way a data
   // cache miss freezes the stage registers of the CPU.
   assign advance = ~out_valid | out_ready;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         out_valid <= 1'b0;
      end else if (advance) begin
         out_valid <= in_valid;   // Bubble clears it
      end
   end

   // Stable while out_valid is high and not taken
   always_ff @(posedge clk) begin
      if (advance) begin
         res_q <= in_res;
      end
   end

   assign out_res = res_q;

endmodule

/* hw/mul_pipeline.sv */
`timescale 1ns/1ps

module mul_pipeline (
   input  logic              clk,
   input  logic              mem_wb_reset,
   input  logic              in_valid,
   output logic              in_ready,
   input  mul_pkg::mul_req_t in_req,
   output logic              out_valid,
   input  logic              out_ready,
   output mul_pkg::mul_res_t out_res
);

   logic               advance;
   logic               m1_valid;
   logic               m2_valid;
   logic               m3_valid;
   logic               m4_valid;
   mul_pkg::mul_mag_t  m1_mag;
   mul_pkg::mul_part_t m2_part;
   mul_pkg::mul_sum_t  m3_sum;
   mul_pkg::mul_res_t  m4_res;

   assign in_ready = advance;   // Accept whenever the pipeline moves

   mul_operand_stage M1 (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .advance      (advance),
      .in_valid     (in_valid),
      .in_req       (in_req),
      .valid        (m1_valid),
      .mag          (m1_mag)
   );

   mul_partial_stage M2 (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .advance      (advance),
      .in_valid     (m1_valid),
      .in_mag       (m1_mag),
      .valid        (m2_valid),
      .part         (m2_part)
   );

   mul_accum_stage M3 (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .advance      (advance),
      .in_valid     (m2_valid),
      .in_part      (m2_part),
      .valid        (m3_valid),
      .sum          (m3_sum)
   );

   mul_flag_stage M4 (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .advance      (advance),
      .in_valid     (m3_valid),
      .in_sum       (m3_sum),
      .valid        (m4_valid),
      .res          (m4_res)
   );

   // Last stage also owns the freeze
   mul_output_stage M5 (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .in_valid     (m4_valid),
      .in_res       (m4_res),
      .out_ready    (out_ready),
      .out_valid    (out_valid),
      .out_res      (out_res),
      .advance      (advance)
   );

endmodule

/* bench/tb_mul_pipeline.sv */
`timescale 1ns/1ps
`include "mul_cfg.svh"

module tb_mul_pipeline;
   import mul_pkg::*;

   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 4;
   localparam int LATENCY      = `MUL_STAGES;
   localparam int N_DIRECTED   = 14;
   localparam int N_STALL      = 4;
   localparam int STALL_HOLD   = 12;
   localparam int N_RANDOM     = 400;
   localparam int DRAIN_LIMIT  = 4 * `MUL_STAGES;
   localparam int STIM_CYCLES  = RESET_CYCLES + N_DIRECTED + N_STALL + STALL_HOLD
                                 + N_RANDOM + 3 * LATENCY;
   localparam int TIMEOUT      = 4 * STIM_CYCLES + 100;

   logic     clk = 1'b0;
   logic     mem_wb_reset;
   logic     in_valid;
   logic     in_ready;
   mul_req_t in_req;
   logic     out_valid;
   logic     out_ready;
   mul_res_t out_res;

   mul_res_t    exp_q[$];     // Expected results in arrival order
   int          acc_q[$];     // Cycle of acceptance for each entry
   logic [31:0] lfsr_state = 32'ha21a8ef1;
   int          cycles = 0;
   int          in_count = 0;
   int          checked = 0;
   int          errors = 0;
   logic        lat_check = 1'b0;
   logic        held_valid = 1'b0;
   mul_res_t    held_res;
   logic [4:0]  tag_n = 5'd0;

   mul_pipeline UUT (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_req       (in_req),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_res      (out_res)
   );

   initial begin
      forever #CLK_HALF clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] rand_operand();
      logic [31:0] sel;
      logic [31:0] v;
      sel = take_bits(2);
      v   = take_bits(32);
      if (sel == 32'd0) begin
         v = {{16{v[15]}}, v[15:0]};   // Small value so the product often fits
      end else if (sel == 32'd1) begin
         case (v[1:0])
            2'd0:    v = 32'h0000_0000;
            2'd1:    v = 32'h0000_0001;
            2'd2:    v = 32'hFFFF_FFFF;
            default: v = 32'h8000_0000;
         endcase
      end
      return v;
   endfunction

   // Expected result straight from the 64-bit product
   function automatic mul_res_t ref_multiply(input mul_req_t req);
      logic [63:0] prod;
      mul_res_t    r;
      if (req.funct == `MUL_FUNCT_MULT) begin
         prod = {{32{req.a[31]}}, req.a} * {{32{req.b[31]}}, req.b};   // Mod 2^64
      end else begin
         prod = {32'd0, req.a} * {32'd0, req.b};
      end
      r.tag  = req.tag;
      r.lo   = prod[31:0];
      r.hi   = prod[63:32];
      r.zero = (prod == 64'd0);
      if (req.funct == `MUL_FUNCT_MULT) begin
         r.overflow = (r.hi != {32{r.lo[31]}});
      end else begin
         r.overflow = (r.hi != 32'd0);
      end
      return r;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
      errors++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
   endtask

   task automatic check_result();
      mul_res_t exp;
      int       acc;
      if (exp_q.size() == 0) begin
         errors++;
         $display("error: result with tag %0d came out with nothing expected", out_res.tag);
      end else begin
         exp = exp_q.pop_front();
         acc = acc_q.pop_front();
         checked++;
         if (out_res.tag !== exp.tag)
            report_mismatch("tag", 32'(out_res.tag), 32'(exp.tag));
         if (out_res.lo !== exp.lo)
            report_mismatch("lo", out_res.lo, exp.lo);
         if (out_res.hi !== exp.hi)
            report_mismatch("hi", out_res.hi, exp.hi);
         if (out_res.zero !== exp.zero)
            report_mismatch("zero", 32'(out_res.zero), 32'(exp.zero));
         if (out_res.overflow !== exp.overflow)
            report_mismatch("overflow", 32'(out_res.overflow), 32'(exp.overflow));
         // One cycle per stage with no stall
         if (lat_check && (cycles - acc) != LATENCY)
            report_mismatch("latency", 32'(cycles - acc), 32'(LATENCY));
      end
   endtask

   // Scoreboard and protocol monitor sampled on the rising edge
   always @(posedge clk) begin
      if (!mem_wb_reset) begin
         if (held_valid) begin
            if (!out_valid)
               report_mismatch("out_valid while held", 32'(out_valid), 32'd1);
            if (out_res !== held_res) begin
               errors++;
               $display("[FAIL] %0t: out_res changed while the output was stalled", $time);
            end
         end
         held_valid = out_valid && !out_ready;
         held_res   = out_res;
         if (out_valid && !out_ready && in_ready)
            report_mismatch("in_ready under back-pressure", 32'(in_ready), 32'd0);
         if (out_valid && out_ready)
            check_result();
         if (in_valid && in_ready) begin
            exp_q.push_back(ref_multiply(in_req));
            acc_q.push_back(cycles);
            in_count++;
         end
      end else begin
         held_valid = 1'b0;
      end
      cycles++;
   end

   task automatic drive_req(input logic [5:0] funct, input logic [4:0] tag,
                            input logic [31:0] a, input logic [31:0] b);
      in_req.funct = funct;
      in_req.tag   = tag;
      in_req.a     = a;
      in_req.b     = b;
   endtask

   // Starts on a falling edge and returns on the falling edge after acceptance
   task automatic send_op(input logic [5:0] funct, input logic [31:0] a,
                          input logic [31:0] b);
      int n;
      n = in_count;
      drive_req(funct, tag_n, a, b);
      tag_n    = tag_n + 5'd1;
      in_valid = 1'b1;
      while (in_count == n) @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("error: %0d results never came out of the pipeline", exp_q.size());
         exp_q.delete();
         acc_q.delete();
      end
   endtask

   initial begin
      while (cycles < TIMEOUT) @(negedge clk);
      $display("error: run stopped at the cycle limit of %0d before finishing", TIMEOUT);
      $display("sim failed");
      $finish;
   end

   initial begin
      logic [31:0] r;
      int          sent;
      int          last_count;
      int          n;
      mem_wb_reset = 1'b1;
      in_valid     = 1'b0;
      in_req       = '0;
      out_ready    = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      mem_wb_reset = 1'b0;
      @(negedge clk);
      if (out_valid !== 1'b0)
         report_mismatch("out_valid after reset", 32'(out_valid), 32'd0);
      if (in_ready !== 1'b1)
         report_mismatch("in_ready after reset", 32'(in_ready), 32'd1);

      // Corner cases back to back with exact latency
      lat_check = 1'b1;
      send_op(`MUL_FUNCT_MULT,  32'h0000_0000, 32'h0000_0000);
      send_op(`MUL_FUNCT_MULT,  32'h0000_0000, 32'h1234_5678);
      send_op(`MUL_FUNCT_MULT,  32'h0000_0001, 32'hFFFF_FFFF);
      send_op(`MUL_FUNCT_MULT,  32'h8000_0000, 32'h8000_0000);
      send_op(`MUL_FUNCT_MULT,  32'h0000_B504, 32'h0000_B504);
      send_op(`MUL_FUNCT_MULT,  32'hFFFF_0000, 32'h0000_8000);   // Exactly -2^31
      send_op(`MUL_FUNCT_MULT,  32'h7FFF_FFFF, 32'h0000_0002);
      send_op(`MUL_FUNCT_MULTU, 32'h0000_0000, 32'h0000_0000);
      send_op(`MUL_FUNCT_MULTU, 32'h0000_0001, 32'hFFFF_FFFF);
      send_op(`MUL_FUNCT_MULTU, 32'h8000_0000, 32'h8000_0000);
      send_op(`MUL_FUNCT_MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      send_op(`MUL_FUNCT_MULTU, 32'h0001_0000, 32'h0000_FFFF);
      send_op(`MUL_FUNCT_MULTU, 32'hFFFF_FFFF, 32'h0000_0001);
      send_op(`MUL_FUNCT_MULTU, 32'h0001_0000, 32'h0001_0000);   // Just 2^32
      wait_drain();
      lat_check = 1'b0;

      // Fill the pipeline against a blocked output
      out_ready = 1'b0;
      send_op(`MUL_FUNCT_MULT,  32'hFFFF_FFF9, 32'h0000_0007);
      send_op(`MUL_FUNCT_MULTU, 32'h1234_5678, 32'h9ABC_DEF0);
      send_op(`MUL_FUNCT_MULT,  32'h8000_0000, 32'h7FFF_FFFF);
      repeat (STALL_HOLD - 4) @(negedge clk);
      n = in_count;
      drive_req(`MUL_FUNCT_MULT, tag_n, 32'hDEAD_BEEF, 32'h0000_0003);
      tag_n    = tag_n + 5'd1;
      in_valid = 1'b1;
      repeat (4) @(negedge clk);
      if (out_valid !== 1'b1 || in_ready !== 1'b0 || in_count != n) begin
         errors++;
         $display("[FAIL] %0t: pipeline did not freeze under back-pressure", $time);
      end
      out_ready = 1'b1;
      while (in_count == n) @(negedge clk);
      in_valid = 1'b0;
      wait_drain();

      // Random traffic with random gaps and stalls
      sent       = 0;
      last_count = in_count;
      while (sent < N_RANDOM) begin
         if (in_valid && in_count != last_count) begin
            sent++;
            in_valid = 1'b0;
         end
         last_count = in_count;
         if (!in_valid && sent < N_RANDOM) begin
            r = take_bits(2);
            if (r != 32'd0) begin
               r = take_bits(1);
               drive_req(r[0] ? `MUL_FUNCT_MULT : `MUL_FUNCT_MULTU, 5'd0, 32'd0, 32'd0);
               r = take_bits(5);
               in_req.tag = r[4:0];
               in_req.a   = rand_operand();
               in_req.b   = rand_operand();
               in_valid   = 1'b1;
            end
         end
         r = take_bits(2);
         out_ready = (r != 32'd0);
         @(negedge clk);
      end
      out_ready = 1'b1;
      wait_drain();

      $display("results checked %0d, errors %0d", checked, errors);
      if (errors == 0 && checked == N_DIRECTED + N_STALL + N_RANDOM) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+include
hw/mul_pkg.sv
hw/mul_operand_stage.sv
hw/mul_partial_stage.sv
hw/mul_accum_stage.sv
hw/mul_flag_stage.sv
hw/mul_output_stage.sv
hw/mul_pipeline.sv
bench/tb_mul_pipeline.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mul_pipeline
DUT_TOP  = mul_pipeline
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(TOOL) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
